/* vga_top.f */
vga_pkg.sv
color_pkg.sv
vga_timing.sv
level_fsm.sv
draw_background.sv
draw_rect.sv
vga_top.sv
vga_top_tb.sv

/* vga_top_tb.sv */
// Self-checking testbench for the VGA pixel pipeline.
// Runs six short frames of 9 lines with random block positions and
// level_up pulses, and checks every output pixel against a model.
module vga_top_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import vga_pkg::*;
  import color_pkg::*;

  localparam int h_active  = 1024;
  localparam int hs_start  = 1024 + 24;         // first hsync pixel
  localparam int hs_end    = hs_start + 136;
  localparam int h_total   = 1344;
  localparam int v_active  = 6;
  localparam int v_total   = 9;                 // 6 + 1 + 1 + 1
  localparam int frame_len = h_total * v_total; // 12096 cycles
  localparam int n_frames  = 6;
  localparam int rect_w    = 32;
  localparam int rect_h    = 4;
  localparam int watchdog_ns = n_frames * frame_len * 10 + 2000;

  logic   pclk = 1'b0;
  logic   rst;
  logic   level_up;
  count_t xpos;
  count_t ypos;
  count_t hcount;
  count_t vcount;
  logic   hsync;
  logic   vsync;
  logic   hblnk;
  logic   vblnk;
  rgb_t   rgb;

  logic [31:0] lcg_state = 32'h6690;
  int edges = 0;        // rising edges since reset released
  int errors = 0;
  int model_level = 1;
  bit req_frame [n_frames];  // frame holds at least one request
  int pulse_a [n_frames];    // pulse offsets in the frame, -1 for none
  int pulse_b [n_frames];

  vga_top #(.v_active(6), .v_front(1), .v_sync(1), .v_back(1)) i_vga_top (
    .pclk, .rst, .level_up, .xpos, .ypos,
    .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb
  );

  always #5 pclk = ~pclk;

  always @(posedge pclk) begin
    if (rst) edges <= 0;
    else edges <= edges + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // value in 0 .. n-1 from the upper state bits
  function int rand_below(input int n);
    lcg_state = lcg_next(lcg_state);
    return int'(lcg_state[30:12]) % n;
  endfunction

  // block on top, then the first matching band
  function automatic rgb_t expected_rgb(input int h, input int v, input logic hb,
                                        input logic vb, input int lvl, input int x,
                                        input int y);
    if (hb || vb) return black;
    if (h >= x && h < x + rect_w && v >= y && v < y + rect_h) return rect_color;
    if (h < stripe_w || h >= h_active - stripe_w)
      return (lvl == 2) ? bg_strip_2 : bg_strip_1;
    if (h < stripe_w + shadow_w || h >= h_active - stripe_w - shadow_w)
      return (lvl == 2) ? bg_strip_sh_2 : bg_strip_sh_1;
    if (h < stripe_w + 2 * shadow_w || h >= h_active - stripe_w - 2 * shadow_w)
      return (lvl == 2) ? bg_main_sh_2 : bg_main_sh_1;
    return bg_main;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    errors++;
    $display("Error %s: expected %0h actual %0h", name, exp_val, act_val);
    $display("TEST FAIL");
    $fatal(1, "output mismatch");
  endtask

  // comparator, sampled mid-cycle where outputs are settled
  always @(negedge pclk) begin
    int   p;
    int   exp_h;
    int   exp_v;
    logic [3:0] exp_sb;
    rgb_t exp_rgb;
    if (rst || edges < 2) begin
      // pipeline still holds reset values
      assert ({hcount, vcount, hsync, vsync, hblnk, vblnk, rgb} == '0)
        else report_mismatch("reset", 0, {hcount, vcount, hsync, vsync, hblnk, vblnk, rgb});
    end else begin
      p = edges - 2;  // two stages behind the counter
      exp_h = p % h_total;
      exp_v = (p / h_total) % v_total;
      if (exp_h == 0 && exp_v == 0) begin
        // new frame, a request from the last frame flips the palette
        if (p > 0 && req_frame[p / frame_len - 1]) model_level = 3 - model_level;
        $display("frame %0d level %0d block at %0d,%0d", p / frame_len, model_level,
                 xpos, ypos);
      end
      assert (hcount == exp_h) else report_mismatch("hcount", exp_h, hcount);
      assert (vcount == exp_v) else report_mismatch("vcount", exp_v, vcount);
      exp_sb = {exp_h >= hs_start && exp_h < hs_end, exp_h >= h_active,
                exp_v == v_active + 1, exp_v >= v_active};
      assert ({hsync, hblnk, vsync, vblnk} == exp_sb)
        else report_mismatch("sync_blank", exp_sb, {hsync, hblnk, vsync, vblnk});
      exp_rgb = expected_rgb(exp_h, exp_v, exp_sb[2], exp_sb[0], model_level, xpos, ypos);
      assert (rgb == exp_rgb) else report_mismatch("rgb", exp_rgb, rgb);
    end
  end

  initial begin
    int f;
    int k;
    int pos;
    rst = 1'b1;
    level_up = 1'b0;
    for (f = 0; f < n_frames; f++) begin
      pulse_a[f] = -1;
      pulse_b[f] = -1;
    end
    pulse_a[1] = 200 + rand_below(5000);    // two pulses, one switch
    pulse_b[1] = 6000 + rand_below(5000);
    pulse_a[3] = 200 + rand_below(11000);   // back to level 1
    if (rand_below(2) == 1) pulse_a[4] = 200 + rand_below(11000);
    for (f = 0; f < n_frames; f++) req_frame[f] = (pulse_a[f] >= 0);
    xpos = count_t'(rand_below(80));  // frame 0 over the left stripe
    ypos = count_t'(rand_below(3));
    repeat (2) @(posedge pclk);
    #1 rst = 1'b0;
    for (k = 1; k <= n_frames * frame_len + 1; k++) begin
      @(posedge pclk);
      #1;
      f = k / frame_len;    // counter frame, two ahead of the output
      pos = k % frame_len;
      level_up = (f < n_frames) && (pos == pulse_a[f] || pos == pulse_b[f]);
      if (pos == 7 * h_total) begin
        // output in vertical blanking, block may move
        if (f == 0) xpos = count_t'(910 + rand_below(81));  // right stripe
        else xpos = count_t'(rand_below(991));
        ypos = count_t'(rand_below(3));
      end
    end
    @(negedge pclk);
    #1;
    if (errors == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "mismatches found");
    end
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("run hung, no end of test after %0d ns", watchdog_ns);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

/* vga_top.sv */
// Top level of the VGA pixel pipeline.
// timing -> background -> player block, two cycles from the counters
// to the outputs. level_up requests the next palette, applied from the
// next frame. All timing and block sizes are set here and passed down.
module vga_top #(
  parameter int h_active = 1024,
  parameter int h_front  = 24,
  parameter int h_sync   = 136,
  parameter int h_back   = 160,
  parameter int v_active = 768,
  parameter int v_front  = 3,
  parameter int v_sync   = 6,
  parameter int v_back   = 29,
  parameter int rect_w   = 32,
  parameter int rect_h   = 4
) (
  input  logic            pclk,
  input  logic            rst,
  input  logic            level_up,
  input  vga_pkg::count_t xpos,
  input  vga_pkg::count_t ypos,
  output vga_pkg::count_t hcount,
  output vga_pkg::count_t vcount,
  output logic            hsync,
  output logic            vsync,
  output logic            hblnk,
  output logic            vblnk,
  output color_pkg::rgb_t rgb
);
  import vga_pkg::*;
  import color_pkg::*;

  // timing counter outputs
  count_t tim_hcount, tim_vcount;
  logic   tim_hsync, tim_hblnk, tim_vsync, tim_vblnk;
  logic   frame_end;
  level_t level;

  // background stage outputs
  count_t bg_hcount, bg_vcount;
  logic   bg_hsync, bg_hblnk, bg_vsync, bg_vblnk;
  rgb_t   bg_rgb;

  vga_timing #(
    .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
    .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
  ) i_vga_timing (
    .pclk, .rst,
    .hcount(tim_hcount), .vcount(tim_vcount),
    .hsync(tim_hsync), .hblnk(tim_hblnk), .vsync(tim_vsync), .vblnk(tim_vblnk),
    .frame_end
  );

  level_fsm i_level_fsm (
    .pclk, .rst, .level_up, .frame_end, .level
  );

  draw_background #(.h_active(h_active)) i_draw_background (
    .pclk, .rst,
    .vcount_in(tim_vcount), .hcount_in(tim_hcount),
    .vsync_in(tim_vsync), .vblnk_in(tim_vblnk),
    .hsync_in(tim_hsync), .hblnk_in(tim_hblnk),
    .level,
    .vcount_out(bg_vcount), .hcount_out(bg_hcount),
    .vsync_out(bg_vsync), .vblnk_out(bg_vblnk),
    .hsync_out(bg_hsync), .hblnk_out(bg_hblnk),
    .rgb_out(bg_rgb)
  );

  draw_rect #(.rect_w(rect_w), .rect_h(rect_h)) i_draw_rect (
    .pclk, .rst,
    .vcount_in(bg_vcount), .hcount_in(bg_hcount),
    .vsync_in(bg_vsync), .vblnk_in(bg_vblnk),
    .hsync_in(bg_hsync), .hblnk_in(bg_hblnk),
    .rgb_in(bg_rgb), .xpos, .ypos,
    .vcount_out(vcount), .hcount_out(hcount),
    .vsync_out(vsync), .vblnk_out(vblnk),
    .hsync_out(hsync), .hblnk_out(hblnk),
    .rgb_out(rgb)
  );

endmodule

/* draw_rect.sv */
// Player block overlay, second stage of the pixel stream.
// Replaces the background colour with rect_color inside the block
// whose top-left corner is xpos, ypos. Everything else is delayed one
// cycle unchanged. xpos and ypos are held during a frame.
module draw_rect #(
  parameter int rect_w = 32,
  parameter int rect_h = 4
) (
  input  logic              pclk,
  input  logic              rst,
  input  vga_pkg::count_t   vcount_in,
  input  vga_pkg::count_t   hcount_in,
  input  logic              vsync_in,
  input  logic              vblnk_in,
  input  logic              hsync_in,
  input  logic              hblnk_in,
  input  color_pkg::rgb_t   rgb_in,
  input  vga_pkg::count_t   xpos,  // block left edge
  input  vga_pkg::count_t   ypos,  // block top line
  output vga_pkg::count_t   vcount_out,
  output vga_pkg::count_t   hcount_out,
  output logic              vsync_out,
  output logic              vblnk_out,
  output logic              hsync_out,
  output logic              hblnk_out,
  output color_pkg::rgb_t   rgb_out
);
  import color_pkg::*;

  logic in_rect;

  // sums are 32 bit, no wrap near the right edge
  assign in_rect = !(hblnk_in || vblnk_in) &&
                   (hcount_in >= xpos) && (hcount_in < xpos + rect_w) &&
                   (vcount_in >= ypos) && (vcount_in < ypos + rect_h);

  always_ff @(posedge pclk) begin
    if (rst) begin
      vcount_out <= '0;
      hcount_out <= '0;
      vsync_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      hsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      rgb_out    <= black;
    end else begin
      vcount_out <= vcount_in;
      hcount_out <= hcount_in;
      vsync_out  <= vsync_in;
      vblnk_out  <= vblnk_in;
      hsync_out  <= hsync_in;
      hblnk_out  <= hblnk_in;
      rgb_out    <= in_rect ? rect_color : rgb_in;  // block on top
    end
  end

  // background blanks to black and the block never draws in blanking
  a_black_in_blank: assert property (@(posedge pclk) disable iff (rst)
    (hblnk_out || vblnk_out) |-> (rgb_out == black));

endmodule

/* draw_background.sv */
// Background drawer, first stage of the pixel stream.
// Paints side stripes, their shadow bands and the main field in the
// palette of the current level, black while blanking. Counts, syncs
// and blanks are delayed one cycle to stay aligned with rgb_out.
module draw_background #(
  parameter int h_active = 1024
) (
  input  logic              pclk,
  input  logic              rst,
  input  vga_pkg::count_t   vcount_in,
  input  vga_pkg::count_t   hcount_in,
  input  logic              vsync_in,
  input  logic              vblnk_in,
  input  logic              hsync_in,
  input  logic              hblnk_in,
  input  vga_pkg::level_t   level,
  output vga_pkg::count_t   vcount_out,
  output vga_pkg::count_t   hcount_out,
  output logic              vsync_out,
  output logic              vblnk_out,
  output logic              hsync_out,
  output logic              hblnk_out,
  output color_pkg::rgb_t   rgb_out
);
  import vga_pkg::*;
  import color_pkg::*;

  // band edges, left side counts up and right side counts down
  localparam int strip_l    = stripe_w;                   // end of left stripe
  localparam int strip_sh_l = stripe_w + shadow_w;
  localparam int main_sh_l  = stripe_w + 2 * shadow_w;
  localparam int strip_r    = h_active - stripe_w;        // start of right stripe
  localparam int strip_sh_r = strip_r - shadow_w;
  localparam int main_sh_r  = strip_r - 2 * shadow_w;

  rgb_t strip_c;
  rgb_t strip_sh_c;
  rgb_t main_sh_c;
  rgb_t rgb_nxt;

  // palette for the current level
  always_comb begin
    if (level == level_two) begin
      strip_c    = bg_strip_2;
      strip_sh_c = bg_strip_sh_2;
      main_sh_c  = bg_main_sh_2;
    end else begin
      strip_c    = bg_strip_1;
      strip_sh_c = bg_strip_sh_1;
      main_sh_c  = bg_main_sh_1;
    end
  end

  // first matching band wins
  always_comb begin
    if (vblnk_in || hblnk_in) rgb_nxt = black;
    else if (hcount_in < strip_l || hcount_in >= strip_r) rgb_nxt = strip_c;
    else if (hcount_in < strip_sh_l || hcount_in >= strip_sh_r) rgb_nxt = strip_sh_c;
    else if (hcount_in < main_sh_l || hcount_in >= main_sh_r) rgb_nxt = main_sh_c;
    else rgb_nxt = bg_main;
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      vcount_out <= '0;
      hcount_out <= '0;
      vsync_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      hsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      rgb_out    <= black;
    end else begin
      vcount_out <= vcount_in;  // pass through, one stage
      hcount_out <= hcount_in;
      vsync_out  <= vsync_in;
      vblnk_out  <= vblnk_in;
      hsync_out  <= hsync_in;
      hblnk_out  <= hblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

/* level_fsm.sv */
// Level state machine.
// Collects level_up pulses into one pending request and switches the
// level only on frame_end, so the palette never changes mid-frame.
// level is decoded from the state and feeds the background drawer.
module level_fsm (
  input  logic            pclk,
  input  logic            rst,
  input  logic            level_up,   // one-cycle request pulse
  input  logic            frame_end,  // one-cycle, last pixel of frame
  output vga_pkg::level_t level
);
  import vga_pkg::*;

  level_state_t state;
  level_state_t state_nxt;
  logic         pending;
  logic         req;

  // a pulse landing on the frame_end cycle still counts for this frame
  assign req = pending | level_up;

  always_comb begin
    state_nxt = state;
    if (frame_end && req) begin
      state_nxt = (state == lvl_one) ? lvl_two : lvl_one;  // toggle
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state   <= lvl_one;
      pending <= 1'b0;
    end else begin
      state <= state_nxt;
      if (frame_end) begin
        pending <= 1'b0;  // request served or nothing to serve
      end else begin
        pending <= req;   // several pulses merge into one
      end
    end
  end

  // output decode
  always_comb begin
    case (state)
      lvl_two: level = level_two;
      default: level = level_one;
    endcase
  end

  a_level_legal: assert property (@(posedge pclk) disable iff (rst)
    (level == level_one) || (level == level_two));

  // palette switch only right after the last pixel of a frame
  a_level_at_frame: assert property (@(posedge pclk) disable iff (rst)
    !$stable(level) |-> $past(frame_end));

endmodule

/* vga_timing.sv */
// VGA timing generator.
// Free-running horizontal and vertical counters with registered sync,
// blank and frame-end outputs. All outputs come straight from flops.
// The eight timing values are set by the top level.
module vga_timing #(
  parameter int h_active = 1024,
  parameter int h_front  = 24,
  parameter int h_sync   = 136,
  parameter int h_back   = 160,
  parameter int v_active = 768,
  parameter int v_front  = 3,
  parameter int v_sync   = 6,
  parameter int v_back   = 29
) (
  input  logic            pclk,
  input  logic            rst,
  output vga_pkg::count_t hcount,
  output vga_pkg::count_t vcount,
  output logic            hsync,
  output logic            hblnk,
  output logic            vsync,
  output logic            vblnk,
  output logic            frame_end  // one cycle, last pixel of frame
);
  import vga_pkg::*;

  localparam int h_total  = h_active + h_front + h_sync + h_back;
  localparam int v_total  = v_active + v_front + v_sync + v_back;
  localparam int hs_start = h_active + h_front;  // first hsync pixel
  localparam int hs_end   = hs_start + h_sync;   // one past last
  localparam int vs_start = v_active + v_front;
  localparam int vs_end   = vs_start + v_sync;

  count_t hcount_nxt;
  count_t vcount_nxt;
  logic   h_wrap;
  logic   v_wrap;

  assign h_wrap = (hcount == count_t'(h_total - 1));  // end of line
  assign v_wrap = (vcount == count_t'(v_total - 1));  // last line

  // next position, the compares below work on it so outputs stay aligned
  always_comb begin
    hcount_nxt = h_wrap ? '0 : hcount + 1'b1;
    vcount_nxt = vcount;
    if (h_wrap) begin
      vcount_nxt = v_wrap ? '0 : vcount + 1'b1;  // step on line wrap
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount    <= '0;  // pixel (0,0) right after reset
      vcount    <= '0;
      hsync     <= 1'b0;
      hblnk     <= 1'b0;
      vsync     <= 1'b0;
      vblnk     <= 1'b0;
      frame_end <= 1'b0;
    end else begin
      hcount    <= hcount_nxt;
      vcount    <= vcount_nxt;
      hblnk     <= (hcount_nxt >= h_active);
      hsync     <= (hcount_nxt >= hs_start) && (hcount_nxt < hs_end);
      vblnk     <= (vcount_nxt >= v_active);
      vsync     <= (vcount_nxt >= vs_start) && (vcount_nxt < vs_end);
      frame_end <= (hcount_nxt == count_t'(h_total - 1)) &&
                   (vcount_nxt == count_t'(v_total - 1));
    end
  end

  // counters never leave the frame
  a_count_range: assert property (@(posedge pclk) disable iff (rst)
    (hcount < h_total) && (vcount < v_total));

endmodule

/* color_pkg.sv */
// Colour definitions for the VGA pixel pipeline.
// 12-bit RGB, 4 bits per channel, plus the palettes of both levels
// and the player block colour.
package color_pkg;

  // r[11:8] g[7:4] b[3:0]
  typedef logic [11:0] rgb_t;

  // blanking
  localparam rgb_t black = 12'h0_0_0;

  // main field, same on every level
  localparam rgb_t bg_main = 12'h1_1_5;

  // level 1, green stripes on dark blue
  localparam rgb_t bg_main_sh_1  = 12'h1_1_8;
  localparam rgb_t bg_strip_1    = 12'h0_9_6;
  localparam rgb_t bg_strip_sh_1 = 12'h0_6_4;

  // level 2, amber stripes
  localparam rgb_t bg_main_sh_2  = 12'h0_4_6;
  localparam rgb_t bg_strip_2    = 12'ha_7_0;
  localparam rgb_t bg_strip_sh_2 = 12'ha_9_0;

  // player block, bright yellow so it shows on both palettes
  localparam rgb_t rect_color = 12'hf_d_3;

endpackage

/* vga_pkg.sv */
// Screen geometry shared by the VGA pixel pipeline.
// Holds the count and level types, the level FSM encoding and the
// side stripe band widths. Modules import it inside their bodies and
// use scoped names in their port lists.
package vga_pkg;

  // horizontal and vertical screen counts
  typedef logic [10:0] count_t;

  // level number as seen by the drawers, legal values 1 and 2
  typedef logic [3:0] level_t;

  localparam level_t level_one = 4'd1;
  localparam level_t level_two = 4'd2;

  // level FSM states
  // the pending request flag lives beside the state register
  typedef enum logic {
    lvl_one,
    lvl_two
  } level_state_t;

  // side stripe geometry in pixels
  localparam int stripe_w = 76;  // outer stripe, each side
  localparam int shadow_w = 4;   // each shadow band inward of the stripe

endpackage
